// File: board_config.svh
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// ----------------------------------------
// Slow tick divider
// ----------------------------------------

`define SLOW_DIV  16  // Clocks between slow ticks, short for sim, millions on the board

// ----------------------------------------
// I2S microphone
// ----------------------------------------

`define SCK_HALF  2   // Clocks per half bit clock, 4 clk per bit
`define MIC_BITS  24  // Sample width, MSB first

// ----------------------------------------
// Board I/O widths
// ----------------------------------------

`define W_LED     8   // LEDs
`define W_KEY     2   // User keys
`define W_SW      3   // User switches, reset switch excluded

`endif

// File: board_pkg.sv
`default_nettype none
`include "board_config.svh"

package board_pkg;

    // ----------------------------------------
    // Plain vectors
    // ----------------------------------------

    typedef logic        [`W_LED   - 1:0] led_t;         // LED pattern
    typedef logic        [`W_KEY   - 1:0] key_t;         // Keys, active high
    typedef logic        [`W_SW    - 1:0] sw_t;          // User switches
    typedef logic signed [`MIC_BITS - 1:0] mic_sample_t; // Signed mic sample
    typedef logic        [7:0]            seg_t;         // abcdefgh, h is dp
    typedef logic        [1:0]            digit_sel_t;   // One-hot digit enable

    // ----------------------------------------
    // Grouped signals
    // ----------------------------------------

    // Full display state, registered at the board edge
    typedef struct packed
    {
        led_t       led;   // LED bar
        seg_t       seg;   // Segments of the active digit
        digit_sel_t digit; // Active digit
    } display_t;

    // Clocks driven out to the microphone
    typedef struct packed
    {
        logic sck;  // Bit clock
        logic ws;   // Word select, low = left
    } i2s_clk_t;

endpackage

`default_nettype wire

// File: slow_tick_gen.sv
`timescale 1ns/1ns
`default_nettype none
`include "board_config.svh"

// One-cycle enable every SLOW_DIV clocks, stays in the clk domain
module slow_tick_gen
(
    input  logic clk,
    input  logic rst,
    output logic slow_tick
);

    localparam DIV_W = $clog2(`SLOW_DIV);                 // Divider width
    localparam [DIV_W - 1:0] DIV_LAST = DIV_W'(`SLOW_DIV - 1); // Terminal value

    logic [DIV_W - 1:0] div_cnt;                          // Free-running divider

    assign slow_tick = (div_cnt == DIV_LAST);             // High on terminal count

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            div_cnt <= '0;                                // Zero at release edge
        else if (slow_tick)
            div_cnt <= '0;                                // Wrap
        else
            div_cnt <= div_cnt + 1'b1;
    end

endmodule

`default_nettype wire

// File: i2s_mic_receiver.sv
`timescale 1ns/1ns
`default_nettype none
`include "board_config.svh"

// I2S master for a MEMS mic, left channel only
module i2s_mic_receiver
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sd,
    output board_pkg::i2s_clk_t    mic_clk,
    output board_pkg::mic_sample_t value,
    output logic                   valid
);

    import board_pkg::*;

    // ----------------------------------------
    // Constants
    // ----------------------------------------

    localparam PRE_W = $clog2(`SCK_HALF + 1);                  // Prescaler width
    localparam [PRE_W - 1:0] PRE_LAST  = PRE_W'(`SCK_HALF - 1); // Half period end
    localparam [4:0]         LAST_SLOT = 5'(`MIC_BITS);         // Slot of the LSB

    // ----------------------------------------
    // Signals
    // ----------------------------------------

    logic [PRE_W - 1:0]      pre_cnt;   // Half period prescaler
    logic                    sck_q;     // Bit clock register
    logic [5:0]              bit_cnt;   // Slot in frame, MSB is ws
    logic [`MIC_BITS - 2:0]  shift_q;   // Bits collected so far

    logic                    sck_edge;  // sck toggles this cycle
    logic                    sck_rise;
    logic                    sck_fall;
    logic [4:0]              slot;      // Slot inside the half-frame
    logic                    capture;   // Sample sd now
    logic                    last_bit;  // 24th data bit

    assign sck_edge = (pre_cnt == PRE_LAST);
    assign sck_rise = sck_edge & ~sck_q;
    assign sck_fall = sck_edge &  sck_q;
    assign slot     = bit_cnt[4:0];

    // Left half only, slot 0 is the delay slot
    assign capture  = sck_rise & ~bit_cnt[5] & (slot != 5'd0) & (slot <= LAST_SLOT);
    assign last_bit = capture & (slot == LAST_SLOT);

    // ----------------------------------------
    // Clock generation
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pre_cnt <= '0;
            sck_q   <= 1'b0;                  // sck idles low
            bit_cnt <= '0;                    // Start in the left half
        end
        else
        begin
            pre_cnt <= sck_edge ? '0 : pre_cnt + 1'b1;
            if (sck_edge)
                sck_q <= ~sck_q;
            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;    // ws moves on sck fall, wraps at 64
        end
    end

    assign mic_clk.sck = sck_q;
    assign mic_clk.ws  = bit_cnt[5];          // Low for slots 0..31

    // ----------------------------------------
    // Data capture
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            shift_q <= '0;
            value   <= '0;
        end
        else
        begin
            if (capture)
                shift_q <= {shift_q[`MIC_BITS - 3:0], sd};  // MSB first
            if (last_bit)
                value <= {shift_q, sd};                      // Full word
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            valid <= 1'b0;
        else
            valid <= last_bit;                // One clk after the 24th sample
    end

endmodule

`default_nettype wire

// File: lab_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "board_config.svh"

// Tick counter with LED and two-digit hex display
module lab_top
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   slow_tick,
    input  board_pkg::key_t        key,
    input  board_pkg::sw_t         sw,
    input  board_pkg::mic_sample_t mic_value,
    input  logic                   mic_valid,
    output board_pkg::display_t    display
);

    import board_pkg::*;

    led_t        count;      // Slow tick count
    led_t        mic_byte;   // Loudest byte of last sample
    digit_sel_t  digit_sel;  // Active digit
    logic [3:0]  nibble;     // Hex shown on the active digit

    // ----------------------------------------
    // Hex to abcdefgh
    // ----------------------------------------

    function automatic seg_t hex_to_seg(input logic [3:0] hex, input logic dp);
        logic [6:0] abcdefg;
        case (hex)
            4'h0:    abcdefg = 7'b1111110;
            4'h1:    abcdefg = 7'b0110000;
            4'h2:    abcdefg = 7'b1101101;
            4'h3:    abcdefg = 7'b1111001;
            4'h4:    abcdefg = 7'b0110011;
            4'h5:    abcdefg = 7'b1011011;
            4'h6:    abcdefg = 7'b1011111;
            4'h7:    abcdefg = 7'b1110000;
            4'h8:    abcdefg = 7'b1111111;
            4'h9:    abcdefg = 7'b1111011;
            4'hA:    abcdefg = 7'b1110111;
            4'hB:    abcdefg = 7'b0011111;  // Lower case b
            4'hC:    abcdefg = 7'b1001110;
            4'hD:    abcdefg = 7'b0111101;  // Lower case d
            4'hE:    abcdefg = 7'b1001111;
            default: abcdefg = 7'b1000111;  // F
        endcase
        return {abcdefg, dp};
    endfunction

    // ----------------------------------------
    // State
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            count     <= '0;
            mic_byte  <= '0;
            digit_sel <= 2'b01;                        // Low digit first
        end
        else
        begin
            if (key[0])
                count <= '0;                           // Clear wins over tick
            else if (slow_tick)
                count <= count + 1'b1;                 // Wraps past 255
            if (mic_valid)
                mic_byte <= mic_value[`MIC_BITS - 1 -: `W_LED];
            digit_sel <= {digit_sel[0], digit_sel[1]}; // Toggle every clk
        end
    end

    // ----------------------------------------
    // Display outputs
    // ----------------------------------------

    assign nibble = digit_sel[0] ? count[3:0] : count[7:4];

    always_comb
    begin
        display.led   = sw[0] ? mic_byte : count;      // Mic or count
        display.seg   = hex_to_seg(nibble, key[1]);    // dp while key[1] held
        display.digit = digit_sel;
    end

endmodule

`default_nettype wire

// File: board_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "board_config.svh"

// Board wrapper around the lab application and the mic receiver
module board_top
(
    input  logic                  clk,
    input  logic                  rst,          // Reset switch
    input  logic                  reset_key_n,  // Reset button, active low
    input  logic [`W_KEY - 1:0]   key_n,        // Raw keys, active low
    input  board_pkg::sw_t        sw,
    input  logic                  mic_sd,
    output logic                  mic_sck,
    output logic                  mic_ws,
    output logic                  mic_lr,
    output board_pkg::led_t       led,
    output board_pkg::seg_t       hgfedcba,
    output board_pkg::digit_sel_t digit
);

    import board_pkg::*;

    // ----------------------------------------
    // Reset and keys
    // ----------------------------------------

    logic         rst_merged;   // Switch or button
    key_t         key_meta;     // First sync stage
    key_t         key;          // Synchronized, active high

    assign rst_merged = rst | ~reset_key_n;

    always_ff @(posedge clk or posedge rst_merged)
    begin
        if (rst_merged)
        begin
            key_meta <= '0;
            key      <= '0;
        end
        else
        begin
            key_meta <= ~key_n;     // Invert to active high
            key      <= key_meta;
        end
    end

    // ----------------------------------------
    // Instances
    // ----------------------------------------

    logic         slow_tick;
    i2s_clk_t     mic_clk;
    mic_sample_t  mic_value;
    logic         mic_valid;
    display_t     display;      // Combinational from the lab
    display_t     display_q;    // Registered at the pins

    slow_tick_gen u_slow_tick
    (
        .clk       ( clk        ),
        .rst       ( rst_merged ),
        .slow_tick ( slow_tick  )
    );

    i2s_mic_receiver u_mic
    (
        .clk     ( clk        ),
        .rst     ( rst_merged ),
        .sd      ( mic_sd     ),
        .mic_clk ( mic_clk    ),
        .value   ( mic_value  ),
        .valid   ( mic_valid  )
    );

    lab_top u_lab
    (
        .clk       ( clk        ),
        .rst       ( rst_merged ),
        .slow_tick ( slow_tick  ),
        .key       ( key        ),
        .sw        ( sw         ),
        .mic_value ( mic_value  ),
        .mic_valid ( mic_valid  ),
        .display   ( display    )
    );

    assign mic_sck = mic_clk.sck;
    assign mic_ws  = mic_clk.ws;
    assign mic_lr  = 1'b0;          // Left channel

    // ----------------------------------------
    // Output registers
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst_merged)
    begin
        if (rst_merged)
            display_q <= '0;        // Dark display during reset
        else
            display_q <= display;   // Glitch-free pins
    end

    assign led   = display_q.led;
    assign digit = display_q.digit;

    // Segment pins are wired h first on the board
    for (genvar i = 0; i < $bits(seg_t); i++)
    begin : g_seg_rev
        assign hgfedcba[i] = display_q.seg[$bits(seg_t) - 1 - i];
    end

endmodule

`default_nettype wire

// File: board_top_assert.sv
`timescale 1ns/1ns
`default_nettype none

// Protocol rules on the board pins, bound into board_top
module board_top_assert
(
    input wire logic       clk,
    input wire logic       rst,        // Merged reset
    input wire logic       sck,        // I2S bit clock
    input wire logic       ws,         // I2S word select
    input wire logic [1:0] digit,      // Registered digit enable
    input wire logic       mic_valid   // Sample strobe from the receiver
);

    // ----------------------------------------
    // I2S clocks
    // ----------------------------------------

    // Bit clock period is four clk
    sck_high_len: assert property (@(posedge clk) disable iff (rst)
        $rose(sck) |-> ##2 $fell(sck))
        else $error("sck high phase is not two clocks");

    sck_low_len: assert property (@(posedge clk) disable iff (rst)
        $fell(sck) |-> ##2 $rose(sck))
        else $error("sck low phase is not two clocks");

    // ws moves only together with an sck fall
    ws_on_fall: assert property (@(posedge clk) disable iff (rst)
        !$stable(ws) |-> $fell(sck))
        else $error("ws changed away from an sck fall");

    // Sample strobe belongs to the left half
    valid_left: assert property (@(posedge clk) disable iff (rst)
        mic_valid |-> !ws)
        else $error("mic_valid outside the left half-frame");

    // ----------------------------------------
    // Display
    // ----------------------------------------

    digit_onehot: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> $onehot(digit))
        else $error("digit is not one-hot");

endmodule

bind board_top board_top_assert u_assert
(
    .clk       ( clk        ),
    .rst       ( rst_merged ),
    .sck       ( mic_sck    ),
    .ws        ( mic_ws     ),
    .digit     ( digit      ),
    .mic_valid ( mic_valid  )
);

`default_nettype wire

// File: board_top_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "board_config.svh"

module board_top_tb;

    import board_pkg::*;

    // ----------------------------------------
    // Run length
    // ----------------------------------------

    localparam int RST_CYC    = 16;
    localparam int COUNT_CYC  = 4200;             // Past one wrap of the count
    localparam int CLEAR_CYC  = 900;
    localparam int MIC_FRAMES = 8;                // Mic words checked on the LEDs
    localparam int MIC_CYC    = MIC_FRAMES * 64 * 4 + 100;
    localparam int CLEAR_BEG  = RST_CYC + COUNT_CYC;
    localparam int MIC_BEG    = CLEAR_BEG + CLEAR_CYC;
    localparam int END_CYC    = MIC_BEG + MIC_CYC;
    localparam int LIMIT_CYC  = END_CYC + 500;    // Margin over the planned run

    logic                clk;
    logic                rst;
    logic                reset_key_n;
    logic [`W_KEY - 1:0] key_n;
    sw_t                 sw;
    logic                mic_sd;
    logic                mic_sck;
    logic                mic_ws;
    logic                mic_lr;
    led_t                led;
    seg_t                hgfedcba;
    digit_sel_t          digit;

    board_top uut
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .reset_key_n ( reset_key_n ),
        .key_n       ( key_n       ),
        .sw          ( sw          ),
        .mic_sd      ( mic_sd      ),
        .mic_sck     ( mic_sck     ),
        .mic_ws      ( mic_ws      ),
        .mic_lr      ( mic_lr      ),
        .led         ( led         ),
        .hgfedcba    ( hgfedcba    ),
        .digit       ( digit       )
    );

    // ----------------------------------------
    // Model state
    // ----------------------------------------

    logic [31:0]          lfsr = 32'h6828;
    int                   cyc = 0;
    int                   err_cnt = 0;      // Wrong values
    int                   other_cnt = 0;    // Other failures
    int                   m_div = 0;        // Tick divider
    key_t                 m_kmeta = '0;     // Key pipeline
    key_t                 m_ksync = '0;
    led_t                 m_count = '0;
    digit_sel_t           m_dsel = 2'b01;
    logic [5:0]           m_slot = '0;      // I2S slot, MSB is ws
    logic [`MIC_BITS-1:0] mic_word = '0;    // Word on the wire
    led_t                 last_top = '0;    // Top byte of last full word
    logic                 prev_sck = 1'b0;
    logic                 prev_ws = 1'b0;
    logic                 sck_seen = 1'b0;
    int                   sck_gap = 0;
    int                   mic_pend = 0;     // Cycles to the mic led check
    int                   mic_checks = 0;
    int                   press_left = 0;
    int                   gap_left = 10;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // Standard seven-segment hex font, abcdefg then dp
    function automatic seg_t seg_pattern(input logic [3:0] hex, input logic dp);
        logic [6:0] s;
        case (hex)
            4'h0: s = 7'h7E;
            4'h1: s = 7'h30;
            4'h2: s = 7'h6D;
            4'h3: s = 7'h79;
            4'h4: s = 7'h33;
            4'h5: s = 7'h5B;
            4'h6: s = 7'h5F;
            4'h7: s = 7'h70;
            4'h8: s = 7'h7F;
            4'h9: s = 7'h7B;
            4'hA: s = 7'h77;
            4'hB: s = 7'h1F;
            4'hC: s = 7'h4E;
            4'hD: s = 7'h3D;
            4'hE: s = 7'h4F;
            default: s = 7'h47;
        endcase
        return {s, dp};
    endfunction

    function automatic seg_t seg_reverse(input seg_t v);
        seg_t r;
        for (int i = 0; i < 8; i++)
            r[i] = v[7 - i];
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
        if (exp_v !== act_v)
        begin
            $display("Fail %s: expected %h, got %h at cycle %0d", name, exp_v, act_v, cyc);
            err_cnt++;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        rst         = 1'b1;
        reset_key_n = 1'b1;
        key_n       = '1;     // Keys released
        sw          = '0;
        mic_sd      = 1'b0;
    end

    // ----------------------------------------
    // Model, checks and stimulus on the falling edge
    // ----------------------------------------

    always @(negedge clk)
    begin
        logic [31:0] r;
        logic        tick;
        logic        led_known;
        led_t        exp_led;
        seg_t        exp_seg;
        digit_sel_t  exp_digit;

        if (cyc <= RST_CYC)
        begin
            check("led", 32'(0), 32'(led));         // Dark outputs in reset
            check("hgfedcba", 32'(0), 32'(hgfedcba));
            check("digit", 32'(0), 32'(digit));
            check("mic_sck", 32'(0), 32'(mic_sck));
            if (cyc == RST_CYC)
                rst = 1'b0;                         // Release
        end
        else
        begin
            // Registers loaded at the last rising edge
            tick      = (m_div == `SLOW_DIV - 1);
            led_known = !sw[0];
            exp_led   = m_count;
            exp_seg   = seg_pattern(m_dsel[0] ? m_count[3:0] : m_count[7:4], m_ksync[1]);
            exp_digit = m_dsel;
            if (m_ksync[0])
                m_count = '0;                       // Clear first
            else if (tick)
                m_count = m_count + 8'd1;
            m_div   = tick ? 0 : m_div + 1;
            m_ksync = m_kmeta;
            m_kmeta = ~key_n;
            m_dsel  = {m_dsel[0], m_dsel[1]};

            if (led_known)
                check("led", 32'(exp_led), 32'(led));
            check("hgfedcba reversed", 32'(exp_seg), 32'(seg_reverse(hgfedcba)));
            check("digit", 32'(exp_digit), 32'(digit));
            check("mic_lr", 32'(0), 32'(mic_lr));

            // Microphone side
            sck_gap++;
            if (!prev_sck && mic_sck)
            begin
                if (sck_seen)
                    check("mic_sck period", 32'(4), 32'(sck_gap));
                sck_seen = 1'b1;
                sck_gap  = 0;
            end
            if (prev_sck && !mic_sck)
            begin
                m_slot = m_slot + 6'd1;
                check("mic_ws", 32'(m_slot[5]), 32'(mic_ws));
                if (!m_slot[5] && m_slot[4:0] == 5'd1)
                begin
                    rand_bits(`MIC_BITS, r);        // Next left word
                    mic_word = r[`MIC_BITS - 1:0];
                end
                if (!m_slot[5] && m_slot[4:0] >= 5'd1 && m_slot[4:0] <= 5'(`MIC_BITS))
                    mic_sd = mic_word[`MIC_BITS - int'(m_slot[4:0])];  // MSB first
                else
                    mic_sd = 1'b0;
                if (!m_slot[5] && m_slot[4:0] == 5'(`MIC_BITS + 1))
                    last_top = mic_word[`MIC_BITS - 1 -: 8];  // Word fully sent
            end
            if (mic_pend > 0)
            begin
                mic_pend--;
                if (mic_pend == 0)
                begin
                    check("led mic byte", 32'(last_top), 32'(led));
                    mic_checks++;
                end
            end
            if (!prev_ws && mic_ws && sw[0] && cyc >= MIC_BEG + 4)
                mic_pend = 8;                       // ws rise plus 8
            prev_sck = mic_sck;
            prev_ws  = mic_ws;
        end

        // Stimulus for the next edge
        if (cyc == RST_CYC)
        begin
            rand_bits(2, r);
            sw = {r[1:0], 1'b0};                    // Count on the LEDs
        end
        else if (cyc >= CLEAR_BEG && cyc < MIC_BEG)
        begin
            if (press_left > 0)
            begin
                key_n[0] = 1'b0;                    // Clear held
                press_left--;
            end
            else
            begin
                key_n[0] = 1'b1;
                if (gap_left > 0)
                    gap_left--;
                else
                begin
                    rand_bits(10, r);
                    press_left = 1 + int'(r[3:0]);
                    gap_left   = 20 + int'(r[9:4]);
                end
            end
            if (cyc % 32 == 0)
            begin
                rand_bits(1, r);
                key_n[1] = r[0];                    // Decimal point key
            end
        end
        else if (cyc == MIC_BEG)
        begin
            key_n = '1;
            sw[0] = 1'b1;                           // Mic byte on the LEDs
        end

        cyc++;
        if (cyc >= LIMIT_CYC)
        begin
            $display("Timeout: run reached %0d cycles without finishing", cyc);
            other_cnt++;
            $display("Errors: %0d value, %0d other", err_cnt, other_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
        else if (mic_checks == MIC_FRAMES)
        begin
            $display("Errors: %0d value, %0d other", err_cnt, other_cnt);
            if (err_cnt == 0 && other_cnt == 0)
                $display("TESTBENCH PASSED");
            else
                $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: board_top.f
+incdir+.
board_pkg.sv
slow_tick_gen.sv
i2s_mic_receiver.sv
lab_top.sv
board_top.sv
board_top_assert.sv
board_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the board testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f board_top.f \
    --top-module board_top_tb -Mdir obj_dir

sim_status=0
./obj_dir/Vboard_top_tb > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log || [ "$sim_status" -ne 0 ] \
    || ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0
